// File: Makefile
TOP = lookback_estimator_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q -F "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: compile.f
hdl/estimator_pkg.sv
hdl/sample_lut.sv
hdl/complex_recursion.sv
hdl/channel_combine.sv
hdl/estimator_ctrl.sv
hdl/lookback_estimator.sv
testbench/estimator_chk.sv
testbench/estimator_monitor.sv
testbench/lookback_estimator_tb.sv

// File: hdl/channel_combine.sv
`timescale 1ns/1ps

module channel_combine (
    input  logic                 clk,
    input  logic                 reset,
    input  estimator_pkg::cplx_t state [estimator_pkg::num_channels],
    output estimator_pkg::fxp_t  result
);
    import estimator_pkg::*;

    fxp_t part_q [num_channels];
    fxp_t part_sum;

    // Stage one, real part of weight * state per channel
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int c = 0; c < num_channels; c++) begin
                part_q[c] <= '0;
            end
        end else begin
            for (int c = 0; c < num_channels; c++) begin
                part_q[c] <= fxp_mul(weight[c].re, state[c].re)
                           - fxp_mul(weight[c].im, state[c].im);
            end
        end
    end

    always_comb begin
        part_sum = '0;
        for (int c = 0; c < num_channels; c++) begin
            part_sum = part_sum + part_q[c];
        end
    end

    // Stage two, wrapped channel sum
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else begin
            result <= part_sum;
        end
    end

endmodule

// File: hdl/complex_recursion.sv
`timescale 1ns/1ps

module complex_recursion #(
    parameter int channel = 0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  estimator_pkg::cplx_t in_value,
    output estimator_pkg::cplx_t state
);
    import estimator_pkg::*;

    localparam cplx_t factor = rec_factor[channel];

    fxp_t in_re;
    fxp_t in_im;
    fxp_t prod_re;
    fxp_t prod_im;

    // Zero input while no sample is valid, state keeps decaying
    assign in_re = in_valid ? in_value.re : '0;
    assign in_im = in_valid ? in_value.im : '0;

    // factor * state
    assign prod_re = fxp_mul(factor.re, state.re) - fxp_mul(factor.im, state.im);
    assign prod_im = fxp_mul(factor.re, state.im) + fxp_mul(factor.im, state.re);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= '0;
        end else begin
            state.re <= in_re + prod_re;
            state.im <= in_im + prod_im;
        end
    end

endmodule

// File: hdl/estimator_ctrl.sv
`timescale 1ns/1ps

module estimator_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic sample_valid,
    output logic lut_valid,
    output logic result_valid
);
    import estimator_pkg::*;

    ctrl_state_t state_q;
    logic [warmup_cnt_w-1:0] accept_count;
    logic [pipe_depth-1:0] valid_pipe;
    logic [pipe_depth-1:0] run_pipe;

    // Warm-up counter, saturates once running
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= idle;
            accept_count <= '0;
        end else if (sample_valid && state_q != running) begin
            accept_count <= accept_count + 1'b1;
            if (accept_count == warmup_cnt_w'(warmup_len - 1)) begin
                state_q <= running;
            end else begin
                state_q <= warmup;
            end
        end
    end

    // Strobe and the running flag seen by each sample travel side by side
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
            run_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[pipe_depth-2:0], sample_valid};
            run_pipe <= {run_pipe[pipe_depth-2:0], state_q == running};
        end
    end

    // First stage lines up with the LUT register
    assign lut_valid = valid_pipe[0];
    assign result_valid = valid_pipe[pipe_depth-1] & run_pipe[pipe_depth-1];

endmodule

// File: hdl/estimator_pkg.sv
package estimator_pkg;

    // Control word layout
    localparam int num_inputs = 2;
    localparam int dsr = 4;
    localparam int word_w = num_inputs * dsr;

    localparam int num_channels = 2;

    // Signed fixed point, Q8.15
    localparam int int_w = 8;
    localparam int frac_w = 15;
    localparam int data_w = 1 + int_w + frac_w;

    localparam int warmup_len = 8;
    localparam int warmup_cnt_w = $clog2(warmup_len + 1);
    localparam int pipe_depth = 4;

    typedef logic signed [data_w-1:0] fxp_t;

    typedef struct packed {
        fxp_t re;
        fxp_t im;
    } cplx_t;

    typedef enum logic [1:0] {
        idle,
        warmup,
        running
    } ctrl_state_t;

    // Per bit weights, added for a one and subtracted for a zero
    localparam fxp_t lut_re [num_channels][word_w] = '{
        '{24'sd3277, -24'sd1638, 24'sd4915, 24'sd819,
          -24'sd2458, 24'sd6554, 24'sd1229, -24'sd3686},
        '{-24'sd2048, 24'sd5734, 24'sd1024, -24'sd4096,
          24'sd2867, 24'sd410, -24'sd1434, 24'sd3072}
    };
    localparam fxp_t lut_im [num_channels][word_w] = '{
        '{24'sd1229, 24'sd2048, -24'sd819, 24'sd3686,
          24'sd614, -24'sd2867, 24'sd4096, 24'sd1638},
        '{24'sd4506, -24'sd1229, 24'sd2458, 24'sd1843,
          -24'sd3277, 24'sd5325, 24'sd205, -24'sd2662}
    };

    // 0.8+0.3j and 0.6-0.5j, both inside the unit circle
    localparam cplx_t rec_factor [num_channels] = '{
        '{re: 24'sd26214, im: 24'sd9830},
        '{re: 24'sd19661, im: -24'sd16384}
    };

    localparam cplx_t weight [num_channels] = '{
        '{re: 24'sd16384, im: 24'sd8192},
        '{re: -24'sd12288, im: 24'sd20480}
    };

    // Full product, floor shift back to the fixed point grid
    function automatic fxp_t fxp_mul(fxp_t a, fxp_t b);
        logic signed [2*data_w-1:0] prod;
        prod = a * b;
        return fxp_t'(prod >>> frac_w);
    endfunction

endpackage

// File: hdl/lookback_estimator.sv
`timescale 1ns/1ps

module lookback_estimator (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [estimator_pkg::word_w-1:0] sample,
    input  logic                             sample_valid,
    output estimator_pkg::fxp_t              result,
    output logic                             result_valid
);
    import estimator_pkg::*;

    cplx_t lut_out [num_channels];
    cplx_t state [num_channels];
    logic lut_valid;

    estimator_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .lut_valid    (lut_valid),
        .result_valid (result_valid)
    );

    for (genvar i = 0; i < num_channels; i++) begin : g_channel
        sample_lut #(
            .channel (i)
        ) u_lut (
            .clk     (clk),
            .reset   (reset),
            .sample  (sample),
            .lut_out (lut_out[i])
        );

        complex_recursion #(
            .channel (i)
        ) u_rec (
            .clk      (clk),
            .reset    (reset),
            .in_valid (lut_valid),
            .in_value (lut_out[i]),
            .state    (state[i])
        );
    end

    channel_combine u_combine (
        .clk    (clk),
        .reset  (reset),
        .state  (state),
        .result (result)
    );

endmodule

// File: hdl/sample_lut.sv
`timescale 1ns/1ps

module sample_lut #(
    parameter int channel = 0
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [estimator_pkg::word_w-1:0] sample,
    output estimator_pkg::cplx_t             lut_out
);
    import estimator_pkg::*;

    fxp_t sum_re;
    fxp_t sum_im;

    // Signed table sum over every comparator bit of the word
    always_comb begin
        sum_re = '0;
        sum_im = '0;
        for (int b = 0; b < word_w; b++) begin
            if (sample[b]) begin
                sum_re = sum_re + lut_re[channel][b];
                sum_im = sum_im + lut_im[channel][b];
            end else begin
                sum_re = sum_re - lut_re[channel][b];
                sum_im = sum_im - lut_im[channel][b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lut_out <= '0;
        end else begin
            lut_out.re <= sum_re;
            lut_out.im <= sum_im;
        end
    end

endmodule

// File: testbench/estimator_chk.sv
`timescale 1ns/1ps

module estimator_chk (
    input logic clk,
    input logic reset,
    input logic sample_valid,
    input logic lut_valid,
    input logic result_valid
);
    import estimator_pkg::*;

    int unsigned fail_count = 0;

    // Both strobes come out of reset low
    strobes_clear: assert property (@(posedge clk) reset |=> !lut_valid && !result_valid)
        else begin
            $error("strobe high in the cycle after reset");
            fail_count++;
        end

    result_has_source: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> $past(sample_valid, pipe_depth))
        else begin
            $error("result_valid without a sample pipe_depth cycles earlier");
            fail_count++;
        end

    lut_follows_sample: assert property (@(posedge clk) !reset |=> lut_valid == $past(sample_valid))
        else begin
            $error("lut_valid does not follow sample_valid by one cycle");
            fail_count++;
        end

endmodule

// File: testbench/estimator_monitor.sv
`timescale 1ns/1ps

module estimator_monitor (
    input logic                             clk,
    input logic                             reset,
    input logic [estimator_pkg::word_w-1:0] sample,
    input logic                             sample_valid,
    input estimator_pkg::fxp_t              result,
    input logic                             result_valid
);
    import estimator_pkg::*;

    cplx_t model_state [num_channels];
    fxp_t exp_result [pipe_depth];
    logic exp_valid [pipe_depth];
    int accepted = 0;
    int test_checks = 0;
    int test_errors = 0;
    int total_checks = 0;
    int total_errors = 0;
    int tests_run = 0;

    function automatic fxp_t fixed_mult(fxp_t a, fxp_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return fxp_t'(p >>> frac_w);
    endfunction

    // Table entries of the one bits count twice, all entries are subtracted once
    function automatic cplx_t lut_model(int ch, logic [word_w-1:0] w);
        fxp_t ones_re;
        fxp_t ones_im;
        fxp_t all_re;
        fxp_t all_im;
        cplx_t v;
        ones_re = '0;
        ones_im = '0;
        all_re = '0;
        all_im = '0;
        for (int b = 0; b < word_w; b++) begin
            all_re = all_re + lut_re[ch][b];
            all_im = all_im + lut_im[ch][b];
            if (w[b]) begin
                ones_re = ones_re + lut_re[ch][b];
                ones_im = ones_im + lut_im[ch][b];
            end
        end
        v.re = ones_re + ones_re - all_re;
        v.im = ones_im + ones_im - all_im;
        return v;
    endfunction

    always @(posedge clk) begin
        cplx_t gin;
        cplx_t next;
        fxp_t sum;
        logic running;
        if (!reset) begin
            test_checks++;
            total_checks++;
            if (result !== exp_result[pipe_depth-1]) begin
                $display("MISMATCH result: got %h expected %h at %0t",
                         result, exp_result[pipe_depth-1], $time);
                test_errors++;
                total_errors++;
            end
            if (result_valid !== exp_valid[pipe_depth-1]) begin
                $display("MISMATCH result_valid: got %h expected %h at %0t",
                         result_valid, exp_valid[pipe_depth-1], $time);
                test_errors++;
                total_errors++;
            end
        end
        for (int i = pipe_depth - 1; i > 0; i--) begin
            exp_result[i] = exp_result[i-1];
            exp_valid[i] = exp_valid[i-1];
        end
        if (reset) begin
            for (int i = 0; i < pipe_depth; i++) begin
                exp_result[i] = '0;
                exp_valid[i] = 1'b0;
            end
            for (int c = 0; c < num_channels; c++) begin
                model_state[c] = '0;
            end
            accepted = 0;
        end else begin
            running = accepted >= warmup_len;
            sum = '0;
            for (int c = 0; c < num_channels; c++) begin
                gin = sample_valid ? lut_model(c, sample) : '0;
                next.re = gin.re + fixed_mult(rec_factor[c].re, model_state[c].re)
                        - fixed_mult(rec_factor[c].im, model_state[c].im);
                next.im = gin.im + fixed_mult(rec_factor[c].re, model_state[c].im)
                        + fixed_mult(rec_factor[c].im, model_state[c].re);
                model_state[c] = next;
                sum = sum + fixed_mult(weight[c].re, next.re) - fixed_mult(weight[c].im, next.im);
            end
            exp_result[0] = sum;
            exp_valid[0] = sample_valid && running;
            if (sample_valid && !running) begin
                accepted++;
            end
        end
    end

    task automatic finish_test(input string name);
        $display("test %-8s %0d checks, %0d errors", name, test_checks, test_errors);
        tests_run++;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic report_counts(input int unsigned assert_fails);
        $display("Summary: %0d tests, %0d checks, %0d mismatches, %0d assertion failures",
                 tests_run, total_checks, total_errors, assert_fails);
    endtask

endmodule

// File: testbench/lookback_estimator_tb.sv
`timescale 1ns/1ps

module lookback_estimator_tb;
    import estimator_pkg::*;

    localparam int reset_len = 4;
    localparam int first_len = 6;
    localparam int warm_len = 20;
    localparam int stream_len = 300;
    localparam int gap_len = 300;
    localparam int restart_len = 60;
    localparam int test_cycles = 3 * (reset_len + 1) + first_len + warm_len + stream_len
                               + gap_len + restart_len + warm_len + 5 * (pipe_depth + 2);
    localparam int max_cycles = test_cycles + 100;

    logic clk = 1'b0;
    logic reset;
    logic [word_w-1:0] sample;
    logic sample_valid;
    fxp_t result;
    logic result_valid;
    integer seed = 32'he947_b55b;
    int cycle_count = 0;

    always #50 clk = ~clk;

    lookback_estimator dut (
        .clk          (clk),
        .reset        (reset),
        .sample       (sample),
        .sample_valid (sample_valid),
        .result       (result),
        .result_valid (result_valid)
    );

    estimator_monitor mon (
        .clk          (clk),
        .reset        (reset),
        .sample       (sample),
        .sample_valid (sample_valid),
        .result       (result),
        .result_valid (result_valid)
    );

    bind estimator_ctrl estimator_chk chk (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .lut_valid    (lut_valid),
        .result_valid (result_valid)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        sample_valid <= 1'b0;
        repeat (reset_len) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic drive_words(input int count, input bit gaps);
        repeat (count) begin
            @(posedge clk);
            sample <= word_w'($random(seed));
            if (gaps) begin
                sample_valid <= ($random(seed) % 2) == 0;
            end else begin
                sample_valid <= 1'b1;
            end
        end
    endtask

    // Lets the last sample reach the output before the test is closed
    task automatic drain_and_report(input string name);
        repeat (pipe_depth + 1) begin
            @(posedge clk);
            sample_valid <= 1'b0;
        end
        @(negedge clk);
        mon.finish_test(name);
    endtask

    initial begin
        reset = 1'b1;
        sample = '0;
        sample_valid = 1'b0;

        repeat (reset_len) @(posedge clk);
        reset <= 1'b0;
        drive_words(first_len, 1'b0);
        drain_and_report("reset");

        apply_reset();
        drive_words(warm_len, 1'b0);
        drain_and_report("warmup");

        drive_words(stream_len, 1'b0);
        drain_and_report("stream");

        drive_words(gap_len, 1'b1);
        drain_and_report("gaps");

        drive_words(restart_len, 1'b0);
        apply_reset();
        drive_words(warm_len, 1'b0);
        drain_and_report("restart");

        mon.report_counts(dut.u_ctrl.chk.fail_count);
        if (mon.total_errors == 0 && dut.u_ctrl.chk.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
